// ==== run_sim.sh ====
#!/bin/sh
# builds the sipo_full testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module sipo_full_tb \
  -f sipo_full.f \
  -o sipo_full_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/sipo_full_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

echo "$sim_out" | grep -qF '*** PASSED ***'
grep_status=$?
if [ $grep_status -ne 0 ]; then
  echo "pass message not found in simulation output"
  exit 1
fi

echo "simulation passed"
exit 0

// ==== sipo_full.f ====
+incdir+source
source/sipo_full_pkg.sv
source/sipo_round_robin.sv
source/sipo_one_fifo.sv
source/sipo_two_fifo.sv
source/sipo_full.sv
verification/sipo_full_assertions.sv
verification/sipo_full_tb.sv

// ==== source/sipo_full.sv ====
`default_nettype none

`include "sipo_full_config.svh"

// serial-in parallel-out assembler
// words come in one per handshake and leave as a full array
// the array is only valid once every slot holds a word
module sipo_full
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,

  // serial input, valid/ready
  input  logic                       valid_i,
  output logic                       ready_o,
  input  sipo_full_pkg::word_t       data_i,

  // parallel output, valid/yumi
  output sipo_full_pkg::word_array_t data_o,
  output logic                       valid_o,
  input  logic                       yumi_i
);

  import sipo_full_pkg::*;

  // per-slot push handshake from the distributor
  logic [`SIPO_ELS-1:0] fifo_valid_in;
  logic [`SIPO_ELS-1:0] fifo_ready;

  // per-slot pop side
  logic [`SIPO_ELS-1:0] fifo_valid_out;
  word_array_t          fifo_data;

  // array complete when every slot has a word
  assign valid_o = &fifo_valid_out;

  // round-robin steering of the input handshake
  sipo_round_robin rr_inst
  (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .valid_o (fifo_valid_in),
    .ready_i (fifo_ready)
  );

  // one fifo per slot, all popped together by yumi
  for (genvar i = 0; i < `SIPO_ELS; i++)
  begin : g_slot
    // slot 0 choice sets the bubble behaviour
    if ((i == 0) && (`SIPO_MIN_BUF == 0))
    begin : g_two
      // spare entry absorbs the next array's first word
      sipo_two_fifo fifo_inst
      (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (fifo_valid_in[i]),
        .ready_o (fifo_ready[i]),
        .data_i  (data_i),
        .valid_o (fifo_valid_out[i]),
        .data_o  (fifo_data[i]),
        .yumi_i  (yumi_i)
      );
    end
    else
    begin : g_one
      sipo_one_fifo fifo_inst
      (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .valid_i (fifo_valid_in[i]),
        .ready_o (fifo_ready[i]),
        .data_i  (data_i),
        .valid_o (fifo_valid_out[i]),
        .data_o  (fifo_data[i]),
        .yumi_i  (yumi_i)
      );
    end

    // output ordering, pure wiring
    if (`SIPO_HI_TO_LO != 0)
    begin : g_rev
      // first word ends up in the top slot
      assign data_o[`SIPO_ELS-1-i] = fifo_data[i];
    end
    else
    begin : g_fwd
      assign data_o[i] = fifo_data[i];
    end
  end

endmodule

`default_nettype wire

// ==== source/sipo_full_config.svh ====
`ifndef SIPO_FULL_CONFIG_SVH
`define SIPO_FULL_CONFIG_SVH

// build-time configuration of the serial-in parallel-out assembler

// bits carried by one input word
`define SIPO_WIDTH 8

// words collected into one output array
`define SIPO_ELS 4

// output ordering
// 0 puts the first received word in slot 0
// 1 puts it in the highest slot
`define SIPO_HI_TO_LO 0

// buffering of slot 0
// 0 gives a two-entry fifo so the next array can start during the pop
// 1 gives a one-entry fifo and one idle input cycle per array
`define SIPO_MIN_BUF 0

`endif

// ==== source/sipo_full_pkg.sv ====
`default_nettype none

`include "sipo_full_config.svh"

package sipo_full_pkg;

  // slot pointer width, kept at one bit even for a single slot
  localparam int unsigned SLOT_IDX_W = (`SIPO_ELS > 1) ? $clog2(`SIPO_ELS) : 1;

  // one data word
  typedef logic [`SIPO_WIDTH-1:0] word_t;

  // index of a slot in the output array
  typedef logic [SLOT_IDX_W-1:0] slot_idx_t;

  // full output array with slot 0 in the low bits
  typedef logic [`SIPO_ELS-1:0][`SIPO_WIDTH-1:0] word_array_t;

  // occupancy of the two-entry fifo
  typedef enum logic [1:0]
  {
    TF_EMPTY = 2'd0,
    TF_ONE   = 2'd1,
    TF_TWO   = 2'd2
  } two_fifo_state_t;

endpackage

`default_nettype wire

// ==== source/sipo_one_fifo.sv ====
`default_nettype none

// single-entry buffer for one slot of the array
// holds its word until the whole array is taken by yumi
module sipo_one_fifo
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // push side, valid/ready
  input  logic                 valid_i,
  output logic                 ready_o,
  input  sipo_full_pkg::word_t data_i,

  // pop side, valid/yumi
  output logic                 valid_o,
  output sipo_full_pkg::word_t data_o,
  input  logic                 yumi_i
);

  import sipo_full_pkg::*;

  // occupancy flag
  logic  full_q;

  // stored word
  word_t data_q;

  logic  push;

  // space only while empty, so no push in the pop cycle
  assign ready_o = ~full_q;
  assign valid_o = full_q;
  assign data_o  = data_q;

  assign push = valid_i & ~full_q;

  // yumi only arrives while full, so it never meets a push
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      full_q <= 1'b0;
    end
    else if (yumi_i)
    begin
      full_q <= 1'b0;
    end
    else if (push)
    begin
      full_q <= 1'b1;
    end
  end

  // data register loads on push only
  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      data_q <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== source/sipo_round_robin.sv ====
`default_nettype none

`include "sipo_full_config.svh"

// steers the input handshake to one slot at a time
// the data bus itself goes to every slot, only the valid is routed
module sipo_round_robin
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // upstream handshake
  input  logic                 valid_i,
  output logic                 ready_o,

  // per-slot handshake toward the fifos
  output logic [`SIPO_ELS-1:0] valid_o,
  input  logic [`SIPO_ELS-1:0] ready_i
);

  import sipo_full_pkg::*;

  // slot that takes the next word
  slot_idx_t ptr_q;

  // last legal pointer value, used for the wrap
  localparam slot_idx_t LAST_SLOT = slot_idx_t'(`SIPO_ELS - 1);

  logic accept;

  // one-hot decode of the pointer
  // only the current slot sees the upstream valid
  always_comb
  begin
    for (int i = 0; i < `SIPO_ELS; i++)
    begin
      valid_o[i] = valid_i && (ptr_q == slot_idx_t'(i));
    end
  end

  // upstream ready follows the selected slot
  assign ready_o = ready_i[ptr_q];

  // a word moves on this edge
  assign accept = valid_i & ready_o;

  // pointer advances once per accepted word
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      ptr_q <= '0;
    end
    else if (accept)
    begin
      // wrap after the last slot
      if (ptr_q == LAST_SLOT)
      begin
        ptr_q <= '0;
      end
      else
      begin
        ptr_q <= ptr_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/sipo_two_fifo.sv ====
`default_nettype none

// two-entry buffer for slot 0
// the spare entry lets the next array's first word land
// in the same cycle that the current array is taken
module sipo_two_fifo
(
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // push side, valid/ready
  input  logic                 valid_i,
  output logic                 ready_o,
  input  sipo_full_pkg::word_t data_i,

  // pop side, valid/yumi
  output logic                 valid_o,
  output sipo_full_pkg::word_t data_o,
  input  logic                 yumi_i
);

  import sipo_full_pkg::*;

  // occupancy
  two_fifo_state_t state_q;
  two_fifo_state_t state_d;

  // storage and pointers into it
  word_t           mem_q [2];
  logic            wr_ptr_q;
  logic            rd_ptr_q;

  logic            push;
  logic            pop;

  // full only with both entries used
  assign ready_o = (state_q != TF_TWO);
  assign valid_o = (state_q != TF_EMPTY);

  // head of the queue
  assign data_o = mem_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  // pop qualified by valid, yumi is not expected while empty anyway
  assign pop  = yumi_i & valid_o;

  // next occupancy
  // push together with pop leaves the count unchanged
  always_comb
  begin
    state_d = state_q;
    case ({push, pop})
      2'b10:
      begin
        // one more entry
        if (state_q == TF_EMPTY)
        begin
          state_d = TF_ONE;
        end
        else
        begin
          state_d = TF_TWO;
        end
      end
      2'b01:
      begin
        // one fewer entry
        if (state_q == TF_TWO)
        begin
          state_d = TF_ONE;
        end
        else
        begin
          state_d = TF_EMPTY;
        end
      end
      default:
      begin
        state_d = state_q;
      end
    endcase
  end

  // control state
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      state_q  <= TF_EMPTY;
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // each pointer toggles on its own event
      if (push)
      begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop)
      begin
        rd_ptr_q <= ~rd_ptr_q;
      end
    end
  end

  // storage write
  always_ff @(posedge clk_i)
  begin
    if (push)
    begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== verification/sipo_full_assertions.sv ====
`default_nettype none

// handshake protocol checks on both sides of the assembler
// bound into sipo_full, so the names follow the dut ports
module sipo_full_assertions
(
  input logic                       clk_i,
  input logic                       rst_n_i,

  // serial input side
  input logic                       valid_i,
  input logic                       ready_i,
  input sipo_full_pkg::word_t       data_i,

  // parallel output side
  input sipo_full_pkg::word_array_t out_data_i,
  input logic                       out_valid_i,
  input logic                       yumi_i
);

  // consumer may only take a complete array
  a_yumi_needs_valid: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    yumi_i |-> out_valid_i
  )
  else $error("yumi_i asserted while valid_o is low");

  // producer keeps a word on the bus until it is accepted
  a_input_held: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (valid_i && !ready_i) |=> (valid_i && $stable(data_i))
  )
  else $error("input word dropped or changed before it was accepted");

  // array stays put while the consumer stalls
  a_output_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (out_valid_i && !yumi_i) |=> (out_valid_i && $stable(out_data_i))
  )
  else $error("output array changed or vanished while stalled");

  // every reset edge leaves the output empty
  a_no_valid_after_reset: assert property (
    @(posedge clk_i)
    !rst_n_i |=> !out_valid_i
  )
  else $error("valid_o high in the cycle after reset");

endmodule

`default_nettype wire

// ==== verification/sipo_full_tb.sv ====
`default_nettype none

`include "sipo_full_config.svh"

// testbench for the serial-in parallel-out assembler
// a reference queue predicts valid_o, ready_o and data_o in every cycle
module sipo_full_tb;

  import sipo_full_pkg::*;

  localparam int ELS = `SIPO_ELS;

  // arrays taken in each phase
  localparam int ORDER_ARRAYS  = 4;
  localparam int STALL_ARRAYS  = 4;
  localparam int STREAM_ARRAYS = 8;
  localparam int RAND_ARRAYS   = 40;
  localparam int NUM_ARRAYS    = ORDER_ARRAYS + STALL_ARRAYS + STREAM_ARRAYS + RAND_ARRAYS;
  // consumer holds off this long in the back-pressure phase
  localparam int STALL_CYCLES  = 3 * ELS;
  // twenty cycles per word is a loose bound
  localparam int WATCHDOG_CYCLES = NUM_ARRAYS * ELS * 20;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  logic        valid_i;
  logic        ready_o;
  word_t       data_i;
  word_array_t data_o;
  logic        valid_o;
  logic        yumi_i;

  // reference model
  word_t       ref_q [$];
  logic        exp_valid;
  logic        exp_ready;
  word_array_t exp_data;
  logic        last_xfer;
  int          arrays_done;
  int unsigned lcg_state;

  always
  begin
    #5 clk_i = ~clk_i;
  end

  sipo_full sipo_full_inst
  (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .data_i  (data_i),
    .data_o  (data_o),
    .valid_o (valid_o),
    .yumi_i  (yumi_i)
  );

  bind sipo_full sipo_full_assertions assertions_inst
  (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .ready_i     (ready_o),
    .data_i      (data_i),
    .out_data_i  (data_o),
    .out_valid_i (valid_o),
    .yumi_i      (yumi_i)
  );

  task automatic report_mismatch(input string name, input string exp_s, input string act_s);
    $display("** Error at time %0t: %s expected %s, got %s", $time, name, exp_s, act_s);
    $display("*** FAILED ***");
    $fatal(1, "value check failed");
  endtask

  // value checks sample just before each rising edge
  a_reset_state: assert property (@(posedge clk_i) $rose(rst_n_i) |-> (ready_o && !valid_o))
    else report_mismatch("ready_o/valid_o", "1/0",
      $sformatf("%b/%b", $sampled(ready_o), $sampled(valid_o)));

  a_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i) valid_o == exp_valid)
    else report_mismatch("valid_o", $sformatf("%b", $sampled(exp_valid)),
      $sformatf("%b", $sampled(valid_o)));

  a_ready: assert property (@(posedge clk_i) disable iff (!rst_n_i) ready_o == exp_ready)
    else report_mismatch("ready_o", $sformatf("%b", $sampled(exp_ready)),
      $sformatf("%b", $sampled(ready_o)));

  a_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    exp_valid |-> (data_o == exp_data))
    else report_mismatch("data_o", $sformatf("%h", $sampled(exp_data)),
      $sformatf("%h", $sampled(data_o)));

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // upper bits of the lcg are the better mixed ones
  function automatic int rand_pct();
    return int'((lcg_next() >> 16) % 32'd100);
  endfunction

  // queue position p lands in slot p mod ELS since every pop takes ELS words
  function automatic logic expect_ready(input int words);
    int slot;
    int occ;
    int cap;
    slot = words % ELS;
    occ  = words / ELS;
    cap  = 1;
    // slot 0 has a spare entry unless minimal buffering
    if ((slot == 0) && (`SIPO_MIN_BUF == 0))
    begin
      cap = 2;
    end
    return occ < cap;
  endfunction

  function automatic word_array_t expect_array();
    word_array_t arr;
    arr = '0;
    for (int j = 0; j < ELS; j++)
    begin
      if (`SIPO_HI_TO_LO != 0)
      begin
        arr[ELS-1-j] = ref_q[j];
      end
      else
      begin
        arr[j] = ref_q[j];
      end
    end
    return arr;
  endfunction

  // one clock cycle of stimulus, driven at the falling edge
  task automatic drive_cycle(input int valid_pct, input int yumi_pct);
    @(negedge clk_i);
    // predictions for the state left by the last rising edge
    exp_valid = (ref_q.size() >= ELS);
    exp_ready = expect_ready(ref_q.size());
    if (exp_valid)
    begin
      exp_data = expect_array();
    end
    // a word not yet taken stays on the bus as it is
    if (!valid_i || last_xfer)
    begin
      valid_i = (rand_pct() < valid_pct);
      data_i  = word_t'(lcg_next() >> 8);
    end
    yumi_i = exp_valid && (rand_pct() < yumi_pct);
    // pop and push that the next rising edge performs
    if (yumi_i)
    begin
      for (int j = 0; j < ELS; j++)
      begin
        ref_q.delete(0);
      end
      arrays_done++;
    end
    last_xfer = valid_i && exp_ready;
    if (last_xfer)
    begin
      ref_q.push_back(data_i);
    end
  endtask

  // stall cycles first with yumi held low, then run until enough arrays are taken
  task automatic run_phase(input int arrays, input int valid_pct, input int yumi_pct,
                           input int stall);
    int target;
    target = arrays_done + arrays;
    repeat (stall) drive_cycle(valid_pct, 0);
    while (arrays_done < target)
    begin
      drive_cycle(valid_pct, yumi_pct);
    end
  endtask

  initial
  begin
    rst_n_i     = 1'b0;
    valid_i     = 1'b0;
    data_i      = '0;
    yumi_i      = 1'b0;
    exp_valid   = 1'b0;
    exp_ready   = 1'b1;
    exp_data    = '0;
    last_xfer   = 1'b0;
    arrays_done = 0;
    lcg_state   = 32'd78169;

    repeat (5) @(negedge clk_i);
    rst_n_i = 1'b1;

    // in-order assembly with input gaps
    run_phase(ORDER_ARRAYS, 60, 100, 0);
    // back-pressure while the fifos fill and the array waits
    run_phase(STALL_ARRAYS, 100, 100, STALL_CYCLES);
    // streaming with yumi in the first valid cycle
    run_phase(STREAM_ARRAYS, 100, 100, 0);
    // random gaps and yumi delays
    run_phase(RAND_ARRAYS, 50, 40, 0);
    // let the state after the last pop be checked at the next rising edge
    drive_cycle(0, 0);
    @(negedge clk_i);

    $display("*** PASSED ***");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout: the test did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire
